// ==== Bender.yml ====
package:
  name: spi_block

sources:
  # RTL in compile order
  - logic/spiPkg.sv
  - logic/ckeGenerator.sv
  - logic/spiByteMaster.sv
  - logic/spiCsr.sv
  - logic/spiBlock.sv

  # Testbench and bound assertions
  - target: test
    files:
      - verification/spiBlock_sva.sv
      - verification/spiBlockTb.sv

// ==== flist.f ====
logic/spiPkg.sv
logic/ckeGenerator.sv
logic/spiByteMaster.sv
logic/spiCsr.sv
logic/spiBlock.sv
verification/spiBlock_sva.sv
verification/spiBlockTb.sv

// ==== logic/ckeGenerator.sv ====
/*
 * Clock-enable divider. While en is high it emits a one-cycle cke pulse
 * every div+1 cycles; while en is low the count is held at zero.
 */
`timescale 1ns/100ps
`default_nettype none

module ckeGenerator
(
	input  wire logic iSCLK,
	input  wire logic rstN,
	input  wire logic en,
	input  wire logic [spiPkg::DIV_WIDTH-1:0] div,
	output logic cke
);

	logic [spiPkg::DIV_WIDTH-1:0] cnt;
	logic cntEnd;

	// Terminal count; >= also recovers when div shrinks mid-count
	assign cntEnd = cnt >= div;

	always_ff @(posedge iSCLK)
	begin
		if (!rstN)
			cnt <= '0;
		else if (!en || cntEnd)
			cnt <= '0;
		else
			cnt <= cnt + 1'b1;
	end

	assign cke = en && cntEnd;

endmodule

`default_nettype wire

// ==== logic/spiBlock.sv ====
/*
 * SPI block top level. Joins the register bank to two clock-enable
 * generators and two byte masters, one for the external SPI port and one
 * for the configuration flash, whose pin enables come out on flashOe.
 */
`timescale 1ns/100ps
`default_nettype none

module spiBlock
(
	input  wire logic iSCLK,
	input  wire logic rstN,
	input  wire spiPkg::usiReq_t usiReq,
	output spiPkg::usiRdResp_t usiRdResp,
	output spiPkg::spiPins_t spiPins,
	input  wire logic spiMiso,
	output spiPkg::spiPins_t flashPins,
	input  wire logic flashMiso,
	output logic [1:0] flashOe
);

	// ----------------------------------------------------------------------
	// Register bank
	// ----------------------------------------------------------------------
	spiPkg::spiCtrl_t spiCtrl;
	spiPkg::spiCtrl_t flashCtrl;
	spiPkg::spiStat_t spiStat;
	spiPkg::spiStat_t flashStat;
	logic spiStart;
	logic flashStart;
	logic [7:0] spiWd;
	logic [7:0] flashWd;
	logic spiCke;
	logic flashCke;

	spiCsr csr (
		.iSCLK(iSCLK),		.rstN(rstN),
		.usiReq(usiReq),	.usiRdResp(usiRdResp),
		.spiCtrl(spiCtrl),	.flashCtrl(flashCtrl),
		.spiStart(spiStart),	.flashStart(flashStart),
		.spiWd(spiWd),		.flashWd(flashWd),
		.spiStat(spiStat),	.flashStat(flashStat),
		.flashOe(flashOe)
	);

	// ----------------------------------------------------------------------
	// External SPI channel
	// ----------------------------------------------------------------------
	ckeGenerator spiCkeGen (
		.iSCLK(iSCLK),		.rstN(rstN),
		.en(spiCtrl.en),	.div(spiCtrl.div),	.cke(spiCke)
	);

	spiByteMaster spiMaster (
		.iSCLK(iSCLK),		.rstN(rstN),
		.ctrl(spiCtrl),		.cke(spiCke),
		.start(spiStart),	.wd(spiWd),
		.pins(spiPins),		.miso(spiMiso),	.stat(spiStat)
	);

	// ----------------------------------------------------------------------
	// Configuration flash channel
	// ----------------------------------------------------------------------
	ckeGenerator flashCkeGen (
		.iSCLK(iSCLK),		.rstN(rstN),
		.en(flashCtrl.en),	.div(flashCtrl.div),	.cke(flashCke)
	);

	spiByteMaster flashMaster (
		.iSCLK(iSCLK),		.rstN(rstN),
		.ctrl(flashCtrl),	.cke(flashCke),
		.start(flashStart),	.wd(flashWd),
		.pins(flashPins),	.miso(flashMiso),	.stat(flashStat)
	);

endmodule

`default_nettype wire

// ==== logic/spiByteMaster.sv ====
/*
 * Single-byte SPI master, mode 0, MSB first. A start pulse loads the byte,
 * then 16 cke pulses alternate SCK rise (sample MISO) and fall (next MOSI).
 * Busy drops and the received byte is presented on the 16th pulse.
 */
`timescale 1ns/100ps
`default_nettype none

module spiByteMaster
(
	input  wire logic iSCLK,
	input  wire logic rstN,
	input  wire spiPkg::spiCtrl_t ctrl,
	input  wire logic cke,
	input  wire logic start,
	input  wire logic [7:0] wd,
	output spiPkg::spiPins_t pins,
	input  wire logic miso,
	output spiPkg::spiStat_t stat
);

	// ----------------------------------------------------------------------
	// Transfer state
	// ----------------------------------------------------------------------
	logic busy;
	logic [3:0] phase;	// cke pulse count within the byte
	logic [7:0] shift;	// out on the top and in at the bottom
	logic sck;
	logic mosi;
	logic [7:0] rxByte;
	logic lastPhase;

	assign lastPhase = phase == 4'd15;

	always_ff @(posedge iSCLK)
	begin
		if (!rstN)
		begin
			busy   <= 1'b0;
			phase  <= 4'd0;
			sck    <= 1'b0;
			mosi   <= 1'b0;
			rxByte <= 8'h00;
		end
		else if (!busy)
		begin
			// Idle with SCK parked low
			sck <= 1'b0;
			if (start)
			begin
				busy  <= 1'b1;
				phase <= 4'd0;
				mosi  <= wd[7];
			end
		end
		else if (!ctrl.en)
		begin
			// Channel switched off mid byte abandons the byte
			busy <= 1'b0;
			sck  <= 1'b0;
		end
		else if (cke)
		begin
			phase <= phase + 1'b1;
			if (!phase[0])
			begin
				// Rising edge
				sck <= 1'b1;
			end
			else
			begin
				// Falling edge
				sck  <= 1'b0;
				mosi <= shift[7];
				if (lastPhase)
				begin
					busy   <= 1'b0;
					rxByte <= shift;
				end
			end
		end
	end

	// Shift register loaded on start and shifted on each SCK rise
	always_ff @(posedge iSCLK)
	begin
		if (!busy && start)
			shift <= wd;
		else if (busy && cke && !phase[0])
			shift <= {shift[6:0], miso};
	end

	// ----------------------------------------------------------------------
	// Outputs
	// ----------------------------------------------------------------------
	// Chip select is a plain software level
	assign pins = '{sck: sck, mosi: mosi, csN: ctrl.csN};
	assign stat = '{busy: busy, rd: rxByte};

endmodule

`default_nettype wire

// ==== logic/spiCsr.sv ====
/*
 * Register bank of the SPI block. Decodes bus strobes aimed at this block,
 * holds both channels' control and divider registers, issues one-cycle
 * start pulses on data writes and returns read data one cycle after rdEn.
 */
`timescale 1ns/100ps
`default_nettype none

module spiCsr
(
	input  wire logic iSCLK,
	input  wire logic rstN,
	input  wire spiPkg::usiReq_t usiReq,
	output spiPkg::usiRdResp_t usiRdResp,
	output spiPkg::spiCtrl_t spiCtrl,
	output spiPkg::spiCtrl_t flashCtrl,
	output logic spiStart,
	output logic flashStart,
	output logic [7:0] spiWd,
	output logic [7:0] flashWd,
	input  wire spiPkg::spiStat_t spiStat,
	input  wire spiPkg::spiStat_t flashStat,
	output logic [1:0] flashOe
);

	// ----------------------------------------------------------------------
	// Address decode
	// ----------------------------------------------------------------------
	logic blockHit;
	logic wrHit;
	logic rdHit;
	logic [7:0] ofs;
	logic rdValid;
	logic [spiPkg::BUS_WIDTH-1:0] rdData;
	logic [spiPkg::BUS_WIDTH-1:0] rdMux;

	assign blockHit = usiReq.adrs[15:8] == spiPkg::BLOCK_ADRS;
	assign wrHit    = usiReq.wrEn && blockHit;
	assign rdHit    = usiReq.rdEn && blockHit;
	assign ofs      = usiReq.adrs[7:0];

	// Read register layout, busy above the byte
	function automatic logic [spiPkg::BUS_WIDTH-1:0] statWord(input spiPkg::spiStat_t s);
		logic [spiPkg::BUS_WIDTH-1:0] w;
		w = '0;
		w[8:0] = {s.busy, s.rd};
		return w;
	endfunction

	// ----------------------------------------------------------------------
	// Writable registers
	// ----------------------------------------------------------------------
	always_ff @(posedge iSCLK)
	begin
		if (!rstN)
		begin
			spiCtrl   <= '{en: 1'b0, csN: 1'b1, div: '0};
			flashCtrl <= '{en: 1'b0, csN: 1'b1, div: '0};
			flashOe   <= 2'b00;
		end
		else if (wrHit)
		begin
			case (ofs)
				spiPkg::SPI_CTRL_OFS:
				begin
					spiCtrl.en  <= usiReq.wd[0];
					spiCtrl.csN <= usiReq.wd[1];
				end
				spiPkg::SPI_DIV_OFS:   spiCtrl.div <= usiReq.wd[spiPkg::DIV_WIDTH-1:0];
				spiPkg::FLASH_CTRL_OFS:
				begin
					flashCtrl.en  <= usiReq.wd[0];
					flashCtrl.csN <= usiReq.wd[1];
					// 01 drives SCK, MOSI and CS toward the flash
					flashOe       <= {1'b0, usiReq.wd[2]};
				end
				spiPkg::FLASH_DIV_OFS: flashCtrl.div <= usiReq.wd[spiPkg::DIV_WIDTH-1:0];
				default: ;
			endcase
		end
	end

	// Start pulses only while the channel is enabled
	always_ff @(posedge iSCLK)
	begin
		if (!rstN)
		begin
			spiStart   <= 1'b0;
			flashStart <= 1'b0;
		end
		else
		begin
			spiStart   <= wrHit && ofs == spiPkg::SPI_WD_OFS && spiCtrl.en;
			flashStart <= wrHit && ofs == spiPkg::FLASH_WD_OFS && flashCtrl.en;
		end
	end

	// Transmit bytes, valid alongside the start pulse
	always_ff @(posedge iSCLK)
	begin
		if (wrHit && ofs == spiPkg::SPI_WD_OFS)
			spiWd <= usiReq.wd[7:0];
		if (wrHit && ofs == spiPkg::FLASH_WD_OFS)
			flashWd <= usiReq.wd[7:0];
	end

	// ----------------------------------------------------------------------
	// Read path
	// ----------------------------------------------------------------------
	always_comb
	begin
		rdMux = '0;
		case (ofs)
			spiPkg::SPI_CTRL_OFS:   rdMux[1:0] = {spiCtrl.csN, spiCtrl.en};
			spiPkg::SPI_DIV_OFS:    rdMux[spiPkg::DIV_WIDTH-1:0] = spiCtrl.div;
			spiPkg::SPI_RD_OFS:     rdMux = statWord(spiStat);
			spiPkg::FLASH_CTRL_OFS: rdMux[2:0] = {flashOe[0], flashCtrl.csN, flashCtrl.en};
			spiPkg::FLASH_DIV_OFS:  rdMux[spiPkg::DIV_WIDTH-1:0] = flashCtrl.div;
			spiPkg::FLASH_RD_OFS:   rdMux = statWord(flashStat);
			// WD offsets are write only
			default:                rdMux = '0;
		endcase
	end

	always_ff @(posedge iSCLK)
	begin
		if (!rstN)
			rdValid <= 1'b0;
		else
			rdValid <= rdHit;
	end

	always_ff @(posedge iSCLK)
	begin
		if (rdHit)
			rdData <= rdMux;
	end

	assign usiRdResp = '{valid: rdValid, rd: rdData};

endmodule

`default_nettype wire

// ==== logic/spiPkg.sv ====
/*
 * Shared definitions for the SPI block: bus widths, the block map value,
 * register offsets and the packed structs passed between the register
 * bank, the byte masters and the testbench. Referenced by scoped names.
 */
`default_nettype none

package spiPkg;

	// ----------------------------------------------------------------------
	// Widths and map
	// ----------------------------------------------------------------------
	localparam int BUS_WIDTH  = 32;
	localparam int ADRS_WIDTH = 16;
	localparam int DIV_WIDTH  = 16;	// SCK divider register width

	// Upper address byte selects this block
	localparam logic [7:0] BLOCK_ADRS = 8'h03;

	// Register offsets in the low address byte
	localparam logic [7:0] SPI_CTRL_OFS   = 8'h00;	// [0] en, [1] csN level
	localparam logic [7:0] SPI_DIV_OFS    = 8'h04;
	localparam logic [7:0] SPI_WD_OFS     = 8'h08;
	localparam logic [7:0] SPI_RD_OFS     = 8'h0C;	// read only
	localparam logic [7:0] FLASH_CTRL_OFS = 8'h10;	// [2] FPGA owns the flash pins
	localparam logic [7:0] FLASH_DIV_OFS  = 8'h14;
	localparam logic [7:0] FLASH_WD_OFS   = 8'h18;
	localparam logic [7:0] FLASH_RD_OFS   = 8'h1C;	// read only

	// ----------------------------------------------------------------------
	// Bus and channel bundles
	// ----------------------------------------------------------------------
	typedef struct packed {
		logic wrEn;
		logic rdEn;
		logic [ADRS_WIDTH-1:0] adrs;
		logic [BUS_WIDTH-1:0] wd;
	} usiReq_t;

	typedef struct packed {
		logic valid;
		logic [BUS_WIDTH-1:0] rd;
	} usiRdResp_t;

	// One channel's software settings
	typedef struct packed {
		logic en;
		logic csN;
		logic [DIV_WIDTH-1:0] div;
	} spiCtrl_t;

	typedef struct packed {
		logic sck;
		logic mosi;
		logic csN;
	} spiPins_t;

	// Busy flag plus last received byte
	typedef struct packed {
		logic busy;
		logic [7:0] rd;
	} spiStat_t;

endpackage

`default_nettype wire

// ==== verification/spiBlockTb.sv ====
/*
 * Random testbench for the SPI block. Drives the register bus, models an
 * SPI slave on each channel and keeps a register model to predict every
 * read. Seeded run, checks counted and summed up in one closing line.
 */
`timescale 1ns/100ps
`default_nettype none

// Mode-0 MSB-first slave that loads its byte when chip select falls
module spiSlaveModel
(
	input  wire logic sck,
	input  wire logic mosi,
	input  wire logic csN,
	input  wire logic [7:0] txByte,
	output logic miso,
	output logic [7:0] rxByte
);

	logic [7:0] txReg;
	int bitIdx;

	initial
	begin
		miso   = 1'b0;
		rxByte = 8'h00;
		bitIdx = 0;
	end

	always @(negedge csN)
	begin
		txReg  = txByte;
		bitIdx = 7;
		miso   = txByte[7];
	end

	// Capture on rise and next bit out on fall
	always @(posedge sck)
		if (!csN)
			rxByte = {rxByte[6:0], mosi};

	always @(negedge sck)
	begin
		if (!csN && bitIdx > 0)
		begin
			bitIdx = bitIdx - 1;
			miso   = txReg[bitIdx];
		end
	end

endmodule

module spiBlockTb;

	logic iSCLK;
	logic rstN;
	spiPkg::usiReq_t usiReq;
	spiPkg::usiRdResp_t usiRdResp;
	spiPkg::spiPins_t spiPins;
	spiPkg::spiPins_t flashPins;
	logic spiMiso;
	logic flashMiso;
	logic [1:0] flashOe;

	// Index 0 is the external channel and 1 the flash channel
	logic [7:0] slaveTx [2];
	logic [7:0] slaveRx [2];
	logic [2:0] ctrlM [2] = '{3'b010, 3'b010};	// csN high out of reset
	logic [15:0] divM [2] = '{16'h0, 16'h0};
	logic [7:0] rdM [2] = '{8'h00, 8'h00};
	int sckRises [2] = '{0, 0};
	int hiLen [2] = '{0, 0};
	logic [1:0] sckPrev = 2'b00;
	logic [1:0] sckNow;
	int errors = 0;
	int checks = 0;

	spiBlock dut (
		.iSCLK(iSCLK),		.rstN(rstN),
		.usiReq(usiReq),	.usiRdResp(usiRdResp),
		.spiPins(spiPins),	.spiMiso(spiMiso),
		.flashPins(flashPins),	.flashMiso(flashMiso),
		.flashOe(flashOe)
	);

	bind spiBlock spiBlock_sva sva (.*);

	spiSlaveModel extSlave (
		.sck(spiPins.sck),	.mosi(spiPins.mosi),	.csN(spiPins.csN),
		.txByte(slaveTx[0]),	.miso(spiMiso),		.rxByte(slaveRx[0])
	);

	spiSlaveModel flashSlave (
		.sck(flashPins.sck),	.mosi(flashPins.mosi),	.csN(flashPins.csN),
		.txByte(slaveTx[1]),	.miso(flashMiso),	.rxByte(slaveRx[1])
	);

	initial
	begin
		iSCLK = 1'b0;
		forever #10 iSCLK = ~iSCLK;
	end

	// Hard stop well past the expected run length
	initial
	begin
		#500000;
		errors++;
		$display("Timeout: the run did not finish in time");
		$display("Checks: %0d, errors: %0d", checks, errors);
		$display("Simulation failed");
		$finish;
	end

	// ----------------------------------------------------------------------
	// Helpers
	// ----------------------------------------------------------------------
	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp) else
		begin
			errors++;
			$display("ERR %0t %s: got %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic nextCycle();
		@(posedge iSCLK);
		#2;
	endtask

	// Flash registers sit 0x10 above the external ones
	function automatic logic [15:0] regAdrs(input bit fl, input logic [7:0] ofs);
		return {spiPkg::BLOCK_ADRS, ofs + (fl ? 8'h10 : 8'h00)};
	endfunction

	function automatic logic [15:0] foreignAdrs(input logic [7:0] ofs);
		return {spiPkg::BLOCK_ADRS + 8'h01, ofs};
	endfunction

	task automatic busWrite(input logic [15:0] adrs, input logic [31:0] data);
		usiReq = '{wrEn: 1'b1, rdEn: 1'b0, adrs: adrs, wd: data};
		nextCycle();
		usiReq.wrEn = 1'b0;
	endtask

	// Response expected one cycle after rdEn within a bounded wait
	task automatic busRead(input logic [15:0] adrs, output logic [31:0] data, output bit got);
		usiReq = '{wrEn: 1'b0, rdEn: 1'b1, adrs: adrs, wd: '0};
		nextCycle();
		usiReq.rdEn = 1'b0;
		got  = 1'b0;
		data = '0;
		for (int n = 0; n < 4 && !got; n++)
		begin
			@(negedge iSCLK);
			if (usiRdResp.valid)
			begin
				got  = 1'b1;
				data = usiRdResp.rd;
				checks++;
				assert (n == 0) else
				begin
					errors++;
					$display("Read response at address %h came %0d cycles late", adrs, n);
				end
			end
		end
		nextCycle();
	endtask

	task automatic readExpect(input logic [15:0] adrs, input logic [31:0] exp);
		logic [31:0] rd;
		bit got;
		busRead(adrs, rd, got);
		checks++;
		assert (got) else
		begin
			errors++;
			$display("No read response at address %h", adrs);
		end
		checkValue($sformatf("usiRdResp.rd[%h]", adrs), rd, exp);
	endtask

	task automatic readNone(input logic [15:0] adrs);
		logic [31:0] rd;
		bit got;
		busRead(adrs, rd, got);
		checks++;
		assert (!got) else
		begin
			errors++;
			$display("Read at foreign address %h was answered", adrs);
		end
	endtask

	// Control write followed by a pin and flashOe check one cycle later
	task automatic writeCtrl(input bit fl, input logic [31:0] val);
		busWrite(regAdrs(fl, spiPkg::SPI_CTRL_OFS), val);
		ctrlM[fl] = fl ? val[2:0] : {1'b0, val[1:0]};
		@(negedge iSCLK);
		checkValue(fl ? "flashPins.csN" : "spiPins.csN",
			fl ? flashPins.csN : spiPins.csN, ctrlM[fl][1]);
		checkValue("flashOe", flashOe, {1'b0, ctrlM[1][2]});
		nextCycle();
	endtask

	task automatic writeDiv(input bit fl, input logic [31:0] val);
		busWrite(regAdrs(fl, spiPkg::SPI_DIV_OFS), val);
		divM[fl] = val[15:0];
	endtask

	task automatic checkRegs();
		for (int c = 0; c < 2; c++)
		begin
			readExpect(regAdrs(c, spiPkg::SPI_CTRL_OFS), {29'b0, ctrlM[c]});
			readExpect(regAdrs(c, spiPkg::SPI_DIV_OFS), {16'b0, divM[c]});
			readExpect(regAdrs(c, spiPkg::SPI_WD_OFS), '0);
			readExpect(regAdrs(c, spiPkg::SPI_RD_OFS), {24'b0, rdM[c]});
		end
		readExpect({spiPkg::BLOCK_ADRS, 8'h20}, '0);
	endtask

	// Poll the read register until busy drops
	task automatic waitIdle(input bit fl, output logic [31:0] rd);
		bit got;
		int polls;
		polls = 0;
		do
		begin
			busRead(regAdrs(fl, spiPkg::SPI_RD_OFS), rd, got);
			polls++;
		end
		while ((!got || rd[8]) && polls < 100);
		checks++;
		assert (got && !rd[8]) else
		begin
			errors++;
			$display("Channel %0d still busy after %0d polls", fl, polls);
		end
	endtask

	task automatic runTransfer(input bit fl, input logic [7:0] tx, input logic [15:0] div,
		input bit overlap);
		logic [31:0] rd;
		bit got;
		int rises;
		int idleRises;
		slaveTx[fl] = $urandom;
		writeDiv(fl, {16'b0, div});
		// Flash channel also takes its pins
		writeCtrl(fl, {29'b0, fl, 2'b11});
		writeCtrl(fl, {29'b0, fl, 2'b01});
		rises     = sckRises[fl];
		idleRises = sckRises[!fl];
		busWrite(regAdrs(fl, spiPkg::SPI_WD_OFS), {24'b0, tx});
		nextCycle();
		busRead(regAdrs(fl, spiPkg::SPI_RD_OFS), rd, got);
		checkValue("stat.busy", rd[8], 1'b1);
		// Second start while busy must be dropped
		if (overlap)
			busWrite(regAdrs(fl, spiPkg::SPI_WD_OFS), {24'b0, ~tx});
		waitIdle(fl, rd);
		rdM[fl] = slaveTx[fl];
		checkValue("usiRdResp.rd", rd, {24'b0, rdM[fl]});
		checkValue(fl ? "flashSlave.rxByte" : "extSlave.rxByte", slaveRx[fl], tx);
		checkValue("SCK rising edges", sckRises[fl] - rises, 8);
		checkValue("idle channel SCK rising edges", sckRises[!fl] - idleRises, 0);
		writeCtrl(fl, {29'b0, fl, 2'b11});
	endtask

	// ----------------------------------------------------------------------
	// SCK monitor for high phase length and edge count
	// ----------------------------------------------------------------------
	assign sckNow = {flashPins.sck, spiPins.sck};

	always @(negedge iSCLK)
	begin
		for (int c = 0; c < 2; c++)
		begin
			if (sckNow[c])
			begin
				hiLen[c]++;
				if (!sckPrev[c])
					sckRises[c]++;
			end
			else if (hiLen[c] != 0)
			begin
				checkValue(c ? "flashPins.sck high cycles" : "spiPins.sck high cycles",
					hiLen[c], divM[c] + 32'd1);
				hiLen[c] = 0;
			end
			sckPrev[c] = sckNow[c];
		end
	end

	// ----------------------------------------------------------------------
	// Stimulus
	// ----------------------------------------------------------------------
	initial
	begin : stimulus
		int rises0;
		bit fl;
		logic [31:0] val;
		logic [7:0] ofs;
		void'($urandom(63));
		usiReq = '{wrEn: 1'b0, rdEn: 1'b0, adrs: '0, wd: '0};
		slaveTx = '{8'h00, 8'h00};
		rstN = 1'b0;
		repeat (2) @(posedge iSCLK);
		#2 rstN = 1'b1;

		// Reset view of pins and registers
		@(negedge iSCLK);
		checkValue("spiPins.sck", spiPins.sck, 1'b0);
		checkValue("spiPins.csN", spiPins.csN, 1'b1);
		checkValue("flashPins.sck", flashPins.sck, 1'b0);
		checkValue("flashPins.csN", flashPins.csN, 1'b1);
		checkValue("flashOe", flashOe, 2'b00);
		checkValue("usiRdResp.valid", usiRdResp.valid, 1'b0);
		nextCycle();
		checkRegs();
		for (int o = 0; o < 32; o += 4)
			readNone(foreignAdrs(o));

		// Random register traffic with foreign writes mixed in
		repeat (24)
		begin
			fl  = $urandom % 2;
			val = $urandom;
			case ($urandom % 3)
				0: writeCtrl(fl, val);
				1: writeDiv(fl, val);
				default:
				begin
					ofs = $urandom % 8;
					busWrite(foreignAdrs(ofs << 2), val);
				end
			endcase
			checkRegs();
		end

		// Byte transfers on each channel
		repeat (6)
			runTransfer(1'b0, $urandom, $urandom % 6, 1'b0);
		repeat (6)
			runTransfer(1'b1, $urandom, $urandom % 6, 1'b0);
		runTransfer(1'b0, $urandom, $urandom % 6, 1'b1);

		// Data write with the channel off starts nothing
		writeCtrl(1'b0, 32'h2);
		rises0 = sckRises[0];
		busWrite(regAdrs(1'b0, spiPkg::SPI_WD_OFS), $urandom);
		nextCycle();
		// Busy stays low where a start would have raised it
		readExpect(regAdrs(1'b0, spiPkg::SPI_RD_OFS), {24'b0, rdM[0]});
		repeat (40) nextCycle();
		checkValue("SCK rising edges while disabled", sckRises[0] - rises0, 0);
		checkRegs();

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verification/spiBlock_sva.sv ====
/*
 * Bound checks for the SPI block top level. Watches the pin protocol of
 * both channels, the one-cycle read response and the state after reset.
 */
`timescale 1ns/100ps
`default_nettype none

module spiBlock_sva
(
	input  wire logic iSCLK,
	input  wire logic rstN,
	input  wire spiPkg::usiReq_t usiReq,
	input  wire spiPkg::usiRdResp_t usiRdResp,
	input  wire spiPkg::spiPins_t spiPins,
	input  wire spiPkg::spiPins_t flashPins,
	input  wire logic [1:0] flashOe
);

	// ----------------------------------------------------------------------
	// Pin protocol
	// ----------------------------------------------------------------------
	// SCK parked low while deselected
	extSckIdle: assert property (@(posedge iSCLK) disable iff (!rstN)
		spiPins.csN |-> !spiPins.sck)
		else $error("External SCK high while chip select is high");
	flashSckIdle: assert property (@(posedge iSCLK) disable iff (!rstN)
		flashPins.csN |-> !flashPins.sck)
		else $error("Flash SCK high while chip select is high");

	// Mode 0, MOSI only moves with the falling edge
	extMosiStable: assert property (@(posedge iSCLK) disable iff (!rstN)
		spiPins.sck |-> $stable(spiPins.mosi))
		else $error("External MOSI changed while SCK was high");
	flashMosiStable: assert property (@(posedge iSCLK) disable iff (!rstN)
		flashPins.sck |-> $stable(flashPins.mosi))
		else $error("Flash MOSI changed while SCK was high");

	// ----------------------------------------------------------------------
	// Bus response and reset state
	// ----------------------------------------------------------------------
	readValidOnce: assert property (@(posedge iSCLK) disable iff (!rstN)
		(usiRdResp.valid && !usiReq.rdEn) |=> !usiRdResp.valid)
		else $error("Read valid held for two cycles with a single rdEn");

	resetState: assert property (@(posedge iSCLK)
		!rstN |=> (!spiPins.sck && spiPins.csN && !flashPins.sck && flashPins.csN
			&& flashOe == 2'b00 && !usiRdResp.valid))
		else $error("Pins or read valid wrong after reset");

endmodule

`default_nettype wire
